/* flist.f */
source/lc3b_pkg.sv
source/lc3b_control.sv
source/lc3b_fetch.sv
source/lc3b_regfile.sv
source/lc3b_pipe_reg.sv
source/lc3b_execute.sv
source/lc3b_mem_stage.sv
source/lc3b_cpu.sv
tb/lc3b_cpu_properties.sv
tb/lc3b_cpu_tb.sv

/* source/lc3b_control.sv */
`timescale 1ns/100ps
`default_nettype none

module lc3b_control (
	input lc3b_pkg::lc3b_opcode opcode,
	input logic imm_mode,
	output lc3b_pkg::lc3b_control_word ctrl
);

always_comb begin
	// Anything not listed stays a NOP
	ctrl = '0;
	case (opcode)
		lc3b_pkg::op_add: begin
			ctrl.aluop = lc3b_pkg::alu_add;
			ctrl.alumux_sel = lc3b_pkg::alumux_sr2;
			ctrl.sr2mux_sel = imm_mode;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
			ctrl.regfilemux_sel = lc3b_pkg::regfilemux_alu;
		end
		lc3b_pkg::op_and: begin
			ctrl.aluop = lc3b_pkg::alu_and;
			ctrl.alumux_sel = lc3b_pkg::alumux_sr2;
			ctrl.sr2mux_sel = imm_mode;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
			ctrl.regfilemux_sel = lc3b_pkg::regfilemux_alu;
		end
		lc3b_pkg::op_not: begin
			ctrl.aluop = lc3b_pkg::alu_not;
			ctrl.alumux_sel = lc3b_pkg::alumux_zero;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
			ctrl.regfilemux_sel = lc3b_pkg::regfilemux_alu;
		end
		lc3b_pkg::op_ldr: begin
			// Address is base plus shifted offset6
			ctrl.aluop = lc3b_pkg::alu_add;
			ctrl.alumux_sel = lc3b_pkg::alumux_offset6;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
			ctrl.mem_read = 1'b1;
			ctrl.regfilemux_sel = lc3b_pkg::regfilemux_mem;
		end
		lc3b_pkg::op_str: begin
			ctrl.aluop = lc3b_pkg::alu_add;
			ctrl.alumux_sel = lc3b_pkg::alumux_offset6;
			ctrl.mem_write = 1'b1;
		end
		lc3b_pkg::op_br: begin
			ctrl.aluop = lc3b_pkg::alu_pass;
			ctrl.alumux_sel = lc3b_pkg::alumux_zero;
			ctrl.is_br = 1'b1;
		end
		default: begin
			ctrl = '0;
		end
	endcase
end

endmodule : lc3b_control

`default_nettype wire

/* source/lc3b_cpu.sv */
`timescale 1ns/100ps
`default_nettype none

module lc3b_cpu #(
	parameter lc3b_pkg::lc3b_word reset_vector = 16'h0000
) (
	input logic clk,
	input logic arst_n,
	output logic ifetch_read,
	output lc3b_pkg::lc3b_line_addr ifetch_address,
	input lc3b_pkg::lc3b_line ifetch_rdata,
	input logic ifetch_resp,
	output logic mem_read,
	output logic mem_write,
	output lc3b_pkg::lc3b_line_addr mem_address,
	output lc3b_pkg::lc3b_line mem_wdata,
	output lc3b_pkg::lc3b_word mem_sel,
	input lc3b_pkg::lc3b_line mem_rdata,
	input logic mem_resp
);

logic advance;
logic branch_taken;
lc3b_pkg::lc3b_word branch_target;
lc3b_pkg::lc3b_word fetch_instruction;
lc3b_pkg::lc3b_word fetch_pc_plus2;

lc3b_pkg::lc3b_if_id_t if_id_d;
lc3b_pkg::lc3b_if_id_t if_id_q;
lc3b_pkg::lc3b_id_ex_t id_ex_d;
lc3b_pkg::lc3b_id_ex_t id_ex_q;
lc3b_pkg::lc3b_ex_mem_t ex_mem_d;
lc3b_pkg::lc3b_ex_mem_t ex_mem_q;
lc3b_pkg::lc3b_mem_wb_t mem_wb_d;
lc3b_pkg::lc3b_mem_wb_t mem_wb_q;

lc3b_pkg::lc3b_opcode opcode;
logic imm_mode;
lc3b_pkg::lc3b_reg dest;
lc3b_pkg::lc3b_reg sr1_idx;
lc3b_pkg::lc3b_reg sr2_idx;
lc3b_pkg::lc3b_word imm5_sext;
lc3b_pkg::lc3b_word offset6_adj;
lc3b_pkg::lc3b_word offset9_adj;
lc3b_pkg::lc3b_control_word ctrl;
lc3b_pkg::lc3b_word reg_a;
lc3b_pkg::lc3b_word reg_b;
lc3b_pkg::lc3b_word reg_st;
lc3b_pkg::lc3b_word sr2_value;

// Whole pipeline moves only when every pending port has answered
assign advance = ifetch_resp && (!(mem_read || mem_write) || mem_resp);

lc3b_fetch #(.reset_vector(reset_vector)) fetch_i (
	.clk,
	.arst_n,
	.advance,
	.branch_taken,
	.branch_target,
	.ifetch_rdata,
	.ifetch_address,
	.ifetch_read,
	.instruction(fetch_instruction),
	.pc_plus2(fetch_pc_plus2)
);

assign if_id_d = '{instruction: fetch_instruction, pc_plus2: fetch_pc_plus2};

lc3b_pipe_reg #(.payload_t(lc3b_pkg::lc3b_if_id_t)) if_id_reg (
	.clk,
	.arst_n,
	.advance,
	.d(if_id_d),
	.q(if_id_q)
);

// Decode fields
assign opcode = lc3b_pkg::lc3b_opcode'(if_id_q.instruction[15:12]);
assign dest = if_id_q.instruction[11:9];
assign sr1_idx = if_id_q.instruction[8:6];
assign imm_mode = if_id_q.instruction[5];
assign sr2_idx = if_id_q.instruction[2:0];
assign imm5_sext = {{11{if_id_q.instruction[4]}}, if_id_q.instruction[4:0]};
assign offset6_adj = {{9{if_id_q.instruction[5]}}, if_id_q.instruction[5:0], 1'b0};
assign offset9_adj = {{6{if_id_q.instruction[8]}}, if_id_q.instruction[8:0], 1'b0};

lc3b_control control_i (
	.opcode,
	.imm_mode,
	.ctrl
);

lc3b_regfile regfile_i (
	.clk,
	.arst_n,
	.load(mem_wb_q.load_regfile && advance),
	.dest(mem_wb_q.dest),
	.in(mem_wb_q.wb_data),
	.src_a(sr1_idx),
	.src_b(sr2_idx),
	.src_st(dest),
	.reg_a,
	.reg_b,
	.reg_st
);

assign sr2_value = ctrl.sr2mux_sel ? imm5_sext : reg_b;

always_comb begin
	id_ex_d.ctrl = ctrl;
	id_ex_d.sr1 = reg_a;
	id_ex_d.sr2 = sr2_value;
	id_ex_d.offset6 = offset6_adj;
	id_ex_d.br_offset = offset9_adj;
	// BR nzp and destination share bits 11 to 9
	id_ex_d.nzp = dest;
	id_ex_d.dest = dest;
	id_ex_d.pc_plus2 = if_id_q.pc_plus2;
	id_ex_d.st_data = reg_st;
end

lc3b_pipe_reg #(.payload_t(lc3b_pkg::lc3b_id_ex_t)) id_ex_reg (
	.clk,
	.arst_n,
	.advance,
	.d(id_ex_d),
	.q(id_ex_q)
);

lc3b_execute execute_i (
	.id_ex(id_ex_q),
	.ex_mem(ex_mem_d)
);

lc3b_pipe_reg #(.payload_t(lc3b_pkg::lc3b_ex_mem_t)) ex_mem_reg (
	.clk,
	.arst_n,
	.advance,
	.d(ex_mem_d),
	.q(ex_mem_q)
);

lc3b_mem_stage mem_stage_i (
	.clk,
	.arst_n,
	.advance,
	.ex_mem(ex_mem_q),
	.mem_rdata,
	.mem_read,
	.mem_write,
	.mem_address,
	.mem_wdata,
	.mem_sel,
	.mem_wb(mem_wb_d),
	.branch_taken,
	.branch_target
);

lc3b_pipe_reg #(.payload_t(lc3b_pkg::lc3b_mem_wb_t)) mem_wb_reg (
	.clk,
	.arst_n,
	.advance,
	.d(mem_wb_d),
	.q(mem_wb_q)
);

endmodule : lc3b_cpu

`default_nettype wire

/* source/lc3b_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module lc3b_execute (
	input lc3b_pkg::lc3b_id_ex_t id_ex,
	output lc3b_pkg::lc3b_ex_mem_t ex_mem
);

lc3b_pkg::lc3b_word alumux_out;
lc3b_pkg::lc3b_word alu_out;
lc3b_pkg::lc3b_word br_target;

always_comb begin
	case (id_ex.ctrl.alumux_sel)
		lc3b_pkg::alumux_sr2: alumux_out = id_ex.sr2;
		lc3b_pkg::alumux_offset6: alumux_out = id_ex.offset6;
		lc3b_pkg::alumux_zero: alumux_out = 16'h0000;
		default: alumux_out = 16'h0000;
	endcase
end

always_comb begin
	case (id_ex.ctrl.aluop)
		lc3b_pkg::alu_add: alu_out = id_ex.sr1 + alumux_out;
		lc3b_pkg::alu_and: alu_out = id_ex.sr1 & alumux_out;
		lc3b_pkg::alu_not: alu_out = ~id_ex.sr1;
		lc3b_pkg::alu_pass: alu_out = alumux_out;
		default: alu_out = alumux_out;
	endcase
end

// Offset is already sign extended and doubled
assign br_target = id_ex.pc_plus2 + id_ex.br_offset;

always_comb begin
	ex_mem.alu_out = alu_out;
	ex_mem.br_target = br_target;
	ex_mem.dest = id_ex.dest;
	ex_mem.nzp = id_ex.nzp;
	ex_mem.st_data = id_ex.st_data;
	ex_mem.load_regfile = id_ex.ctrl.load_regfile;
	ex_mem.load_cc = id_ex.ctrl.load_cc;
	ex_mem.mem_read = id_ex.ctrl.mem_read;
	ex_mem.mem_write = id_ex.ctrl.mem_write;
	ex_mem.regfilemux_sel = id_ex.ctrl.regfilemux_sel;
	ex_mem.is_br = id_ex.ctrl.is_br;
end

endmodule : lc3b_execute

`default_nettype wire

/* source/lc3b_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module lc3b_fetch #(
	parameter lc3b_pkg::lc3b_word reset_vector = 16'h0000
) (
	input logic clk,
	input logic arst_n,
	input logic advance,
	input logic branch_taken,
	input lc3b_pkg::lc3b_word branch_target,
	input lc3b_pkg::lc3b_line ifetch_rdata,
	output lc3b_pkg::lc3b_line_addr ifetch_address,
	output logic ifetch_read,
	output lc3b_pkg::lc3b_word instruction,
	output lc3b_pkg::lc3b_word pc_plus2
);

lc3b_pkg::lc3b_word pc;
logic read_en;

assign pc_plus2 = pc + 16'd2;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		pc <= reset_vector;
		read_en <= 1'b0;
	end else begin
		read_en <= 1'b1;
		// Redirect comes from the memory stage on the same advance
		if (advance) begin
			pc <= branch_taken ? branch_target : pc_plus2;
		end
	end
end

assign ifetch_read = read_en;
assign ifetch_address = pc[15:4];

// Word slot within the line
assign instruction = ifetch_rdata[{pc[3:1], 4'b0000} +: 16];

endmodule : lc3b_fetch

`default_nettype wire

/* source/lc3b_mem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module lc3b_mem_stage (
	input logic clk,
	input logic arst_n,
	input logic advance,
	input lc3b_pkg::lc3b_ex_mem_t ex_mem,
	input lc3b_pkg::lc3b_line mem_rdata,
	output logic mem_read,
	output logic mem_write,
	output lc3b_pkg::lc3b_line_addr mem_address,
	output lc3b_pkg::lc3b_line mem_wdata,
	output lc3b_pkg::lc3b_word mem_sel,
	output lc3b_pkg::lc3b_mem_wb_t mem_wb,
	output logic branch_taken,
	output lc3b_pkg::lc3b_word branch_target
);

lc3b_pkg::lc3b_word load_word;
lc3b_pkg::lc3b_word wb_data;
lc3b_pkg::lc3b_nzp gen_cc;
lc3b_pkg::lc3b_nzp cc;

assign mem_read = ex_mem.mem_read;
assign mem_write = ex_mem.mem_write;
assign mem_address = ex_mem.alu_out[15:4];

// Store word in every slot, byte enables pick the addressed one
assign mem_wdata = {8{ex_mem.st_data}};
assign mem_sel = 16'h0003 << {ex_mem.alu_out[3:1], 1'b0};

assign load_word = mem_rdata[{ex_mem.alu_out[3:1], 4'b0000} +: 16];

assign wb_data = (ex_mem.regfilemux_sel == lc3b_pkg::regfilemux_mem) ? load_word
	: ex_mem.alu_out;

always_comb begin
	gen_cc[2] = wb_data[15];
	gen_cc[1] = (wb_data == 16'h0000);
	gen_cc[0] = !wb_data[15] && (wb_data != 16'h0000);
end

// Reset value is the Z flag
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		cc <= 3'b010;
	end else if (advance && ex_mem.load_cc) begin
		cc <= gen_cc;
	end
end

// Compares against flags of the previous instruction
assign branch_taken = ex_mem.is_br && ((ex_mem.nzp & cc) != 3'b000);
assign branch_target = ex_mem.br_target;

always_comb begin
	mem_wb.wb_data = wb_data;
	mem_wb.dest = ex_mem.dest;
	mem_wb.load_regfile = ex_mem.load_regfile;
end

endmodule : lc3b_mem_stage

`default_nettype wire

/* source/lc3b_pipe_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module lc3b_pipe_reg #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic arst_n,
	input logic advance,
	input payload_t d,
	output payload_t q
);

// All-zero payload is a bubble
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		q <= '0;
	end else if (advance) begin
		q <= d;
	end
end

endmodule : lc3b_pipe_reg

`default_nettype wire

/* source/lc3b_pkg.sv */
`default_nettype none

package lc3b_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [127:0] lc3b_line;
	typedef logic [11:0] lc3b_line_addr;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp;

	// Standard LC-3b opcode encoding
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} lc3b_aluop;

	// Second ALU operand
	typedef enum logic [1:0] {
		alumux_sr2,
		alumux_offset6,
		alumux_zero
	} lc3b_alumux_sel;

	typedef enum logic {
		regfilemux_alu,
		regfilemux_mem
	} lc3b_regfilemux_sel;

	typedef struct packed {
		lc3b_aluop aluop;
		lc3b_alumux_sel alumux_sel;
		logic sr2mux_sel;
		logic load_regfile;
		logic load_cc;
		logic mem_read;
		logic mem_write;
		lc3b_regfilemux_sel regfilemux_sel;
		logic is_br;
	} lc3b_control_word;

	typedef struct packed {
		lc3b_word instruction;
		lc3b_word pc_plus2;
	} lc3b_if_id_t;

	typedef struct packed {
		lc3b_control_word ctrl;
		lc3b_word sr1;
		lc3b_word sr2;
		lc3b_word offset6;
		lc3b_word br_offset;
		lc3b_nzp nzp;
		lc3b_reg dest;
		lc3b_word pc_plus2;
		lc3b_word st_data;
	} lc3b_id_ex_t;

	typedef struct packed {
		lc3b_word alu_out;
		lc3b_word br_target;
		lc3b_reg dest;
		lc3b_nzp nzp;
		lc3b_word st_data;
		logic load_regfile;
		logic load_cc;
		logic mem_read;
		logic mem_write;
		lc3b_regfilemux_sel regfilemux_sel;
		logic is_br;
	} lc3b_ex_mem_t;

	typedef struct packed {
		lc3b_word wb_data;
		lc3b_reg dest;
		logic load_regfile;
	} lc3b_mem_wb_t;

endpackage : lc3b_pkg

`default_nettype wire

/* source/lc3b_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module lc3b_regfile (
	input logic clk,
	input logic arst_n,
	input logic load,
	input lc3b_pkg::lc3b_reg dest,
	input lc3b_pkg::lc3b_word in,
	input lc3b_pkg::lc3b_reg src_a,
	input lc3b_pkg::lc3b_reg src_b,
	input lc3b_pkg::lc3b_reg src_st,
	output lc3b_pkg::lc3b_word reg_a,
	output lc3b_pkg::lc3b_word reg_b,
	output lc3b_pkg::lc3b_word reg_st
);

lc3b_pkg::lc3b_word data [8];

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		data <= '{default: '0};
	end else if (load) begin
		data[dest] <= in;
	end
end

// Bypass the write so decode sees writeback in the same cycle
assign reg_a = (load && dest == src_a) ? in : data[src_a];
assign reg_b = (load && dest == src_b) ? in : data[src_b];
assign reg_st = (load && dest == src_st) ? in : data[src_st];

endmodule : lc3b_regfile

`default_nettype wire

/* tb/lc3b_cpu_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module lc3b_cpu_properties (
	input logic clk,
	input logic arst_n,
	input logic ifetch_read,
	input lc3b_pkg::lc3b_line_addr ifetch_address,
	input logic ifetch_resp,
	input logic mem_read,
	input logic mem_write,
	input lc3b_pkg::lc3b_line_addr mem_address,
	input lc3b_pkg::lc3b_line mem_wdata,
	input lc3b_pkg::lc3b_word mem_sel,
	input logic mem_resp
);

// The data port carries one direction at a time
one_direction: assert property (@(posedge clk) disable iff (!arst_n)
	!(mem_read && mem_write))
	else $error("mem_read and mem_write are both high");

// A pending data access holds its request until the response
data_port_steady: assert property (@(posedge clk) disable iff (!arst_n)
	(mem_read || mem_write) && !mem_resp |=> $stable(mem_address) && $stable(mem_wdata)
		&& $stable(mem_sel) && $stable(mem_read) && $stable(mem_write))
	else $error("Data port request changed before mem_resp");

fetch_address_steady: assert property (@(posedge clk) disable iff (!arst_n)
	ifetch_read && !ifetch_resp |=> $stable(ifetch_address))
	else $error("ifetch_address changed before ifetch_resp");

no_write_after_reset: assert property (@(posedge clk)
	$rose(arst_n) |-> !mem_write)
	else $error("mem_write is high in the first cycle after reset");

endmodule : lc3b_cpu_properties

`default_nettype wire

/* tb/lc3b_cpu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module lc3b_cpu_tb;

localparam logic [15:0] reset_vector = 16'h0046;
localparam logic [31:0] lcg_seed = 32'h8b3c;
// Data base is a byte address, data_word the matching word index
localparam logic [15:0] data_base = 16'h2000;
localparam int data_word = 16'h1000;
localparam logic [15:0] done_marker = 16'h600d;
localparam int done_slot = 31;
localparam int wait_limit = 20000;

logic clk;
logic arst_n;
logic ifetch_read;
lc3b_pkg::lc3b_line_addr ifetch_address;
lc3b_pkg::lc3b_line ifetch_rdata;
logic ifetch_resp;
logic mem_read;
logic mem_write;
lc3b_pkg::lc3b_line_addr mem_address;
lc3b_pkg::lc3b_line mem_wdata;
lc3b_pkg::lc3b_word mem_sel;
lc3b_pkg::lc3b_line mem_rdata;
logic mem_resp;

logic [15:0] mem_words [32768];
logic [15:0] program_q [$];
logic [31:0] latency_state;
logic [31:0] operand_state;
int fetch_wait;
int data_wait;
int test_errors;
int checks;
int passed_tests;
int failed_tests;

lc3b_cpu #(.reset_vector(reset_vector)) lc3b_cpu_i (
	.clk,
	.arst_n,
	.ifetch_read,
	.ifetch_address,
	.ifetch_rdata,
	.ifetch_resp,
	.mem_read,
	.mem_write,
	.mem_address,
	.mem_wdata,
	.mem_sel,
	.mem_rdata,
	.mem_resp
);

bind lc3b_cpu lc3b_cpu_properties properties_i (.*);

initial begin
	clk = 1'b0;
	forever begin
		#2 clk = ~clk;
	end
end

function automatic logic [31:0] lcg_step(input logic [31:0] state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

function automatic int random_latency();
	latency_state = lcg_step(latency_state);
	return 1 + int'(latency_state[31:30]);
endfunction

function automatic logic [15:0] random_word();
	operand_state = lcg_step(operand_state);
	return operand_state[31:16];
endfunction

// Odd multiplier keeps every word index distinct
function automatic logic [15:0] fill_value(input int index);
	return 16'(index * 40763) ^ 16'h5a5a;
endfunction

function automatic lc3b_pkg::lc3b_line read_line(input lc3b_pkg::lc3b_line_addr line);
	lc3b_pkg::lc3b_line value;
	for (int w = 0; w < 8; w++) begin
		value[w * 16 +: 16] = mem_words[int'(line) * 8 + w];
	end
	return value;
endfunction

task automatic write_line(input lc3b_pkg::lc3b_line_addr line, input lc3b_pkg::lc3b_line wdata,
	input lc3b_pkg::lc3b_word sel);
	for (int w = 0; w < 8; w++) begin
		if (sel[2 * w]) begin
			mem_words[int'(line) * 8 + w][7:0] = wdata[w * 16 +: 8];
		end
		if (sel[2 * w + 1]) begin
			mem_words[int'(line) * 8 + w][15:8] = wdata[w * 16 + 8 +: 8];
		end
	end
endtask

// Both ports in one process so latency draws come in a fixed order
initial begin
	ifetch_rdata = '0;
	ifetch_resp = 1'b0;
	mem_rdata = '0;
	mem_resp = 1'b0;
	fetch_wait = 0;
	data_wait = 0;
	latency_state = lcg_seed;
	forever begin
		@(negedge clk);
		if (!arst_n) begin
			ifetch_resp = 1'b0;
			mem_resp = 1'b0;
			fetch_wait = 0;
			data_wait = 0;
		end else begin
			if (ifetch_resp) begin
				ifetch_resp = 1'b0;
			end else if (ifetch_read) begin
				if (fetch_wait == 0) begin
					fetch_wait = random_latency();
				end
				fetch_wait--;
				if (fetch_wait == 0) begin
					ifetch_rdata = read_line(ifetch_address);
					ifetch_resp = 1'b1;
				end
			end
			if (mem_resp) begin
				mem_resp = 1'b0;
			end else if (mem_read || mem_write) begin
				if (data_wait == 0) begin
					data_wait = random_latency();
				end
				data_wait--;
				if (data_wait == 0) begin
					if (mem_write) begin
						write_line(mem_address, mem_wdata, mem_sel);
					end else begin
						mem_rdata = read_line(mem_address);
					end
					mem_resp = 1'b1;
				end
			end
		end
	end
end

function automatic logic [15:0] alu_instr(input lc3b_pkg::lc3b_opcode op, input logic [2:0] dr,
	input logic [2:0] sr1, input logic imm, input logic [4:0] field);
	return {op, dr, sr1, imm, field};
endfunction

function automatic logic [15:0] mem_instr(input lc3b_pkg::lc3b_opcode op, input logic [2:0] r,
	input logic [2:0] base, input logic [5:0] offset);
	return {op, r, base, offset};
endfunction

function automatic logic [15:0] branch_instr(input logic [2:0] nzp, input logic [8:0] offset);
	return {lc3b_pkg::op_br, nzp, offset};
endfunction

// Expected result from the ISA rules
function automatic logic [15:0] expected_alu(input lc3b_pkg::lc3b_opcode op,
	input logic [15:0] a, input logic [15:0] b, input logic imm, input logic [4:0] imm5);
	logic [15:0] operand;
	operand = imm ? {{11{imm5[4]}}, imm5} : b;
	case (op)
		lc3b_pkg::op_add: return a + operand;
		lc3b_pkg::op_and: return a & operand;
		lc3b_pkg::op_not: return ~a;
		default: return 16'hxxxx;
	endcase
endfunction

function automatic bit expected_taken(input logic [2:0] nzp, input logic [15:0] value);
	logic [2:0] flags;
	flags = {value[15], value == 16'h0000, !value[15] && value != 16'h0000};
	return (nzp & flags) != 3'b000;
endfunction

task automatic append_instr(input logic [15:0] instr);
	program_q.push_back(instr);
endtask

// Two NOPs keep the next reader clear of the write
task automatic append_with_gap(input logic [15:0] instr);
	program_q.push_back(instr);
	program_q.push_back(16'h0000);
	program_q.push_back(16'h0000);
endtask

task automatic emit_prologue();
	append_instr(mem_instr(lc3b_pkg::op_ldr, 3'd7, 3'd0, 6'd0));
	append_with_gap(mem_instr(lc3b_pkg::op_ldr, 3'd6, 3'd0, 6'd1));
endtask

task automatic emit_epilogue();
	append_instr(mem_instr(lc3b_pkg::op_str, 3'd6, 3'd7, 6'(done_slot)));
	append_instr(branch_instr(3'b111, 9'h1ff));
endtask

task automatic hold_reset();
	@(negedge clk);
	arst_n = 1'b0;
	repeat (8) @(negedge clk);
	for (int i = 0; i < 32768; i++) begin
		mem_words[i] = (i < data_word) ? 16'h0000 : fill_value(i);
	end
	// Constant pool below the reset vector
	mem_words[0] = data_base;
	mem_words[1] = done_marker;
	program_q.delete();
endtask

task automatic run_program(input string name, output bit finished);
	int cycles;
	for (int i = 0; i < program_q.size(); i++) begin
		mem_words[reset_vector / 2 + i] = program_q[i];
	end
	@(negedge clk);
	arst_n = 1'b1;
	cycles = 0;
	while (mem_words[data_word + done_slot] !== done_marker && cycles < wait_limit) begin
		@(negedge clk);
		cycles++;
	end
	finished = (mem_words[data_word + done_slot] === done_marker);
	if (!finished) begin
		$display("Timeout in test %s: the final store never reached memory", name);
		test_errors++;
	end
endtask

task automatic check_word(input string name, input int slot, input logic [15:0] expected);
	logic [15:0] actual;
	actual = mem_words[data_word + slot];
	checks++;
	assert (actual === expected) else begin
		$display("Mismatch in test %s at data word %0d: expected %h, actual %h", name, slot,
			expected, actual);
		test_errors++;
	end
endtask

task automatic finish_test(input string name);
	if (test_errors == 0) begin
		$display("Test %s passed", name);
		passed_tests++;
	end else begin
		$display("Test %s failed with %0d errors", name, test_errors);
		failed_tests++;
	end
	test_errors = 0;
endtask

task automatic test_reset();
	int cycles;
	hold_reset();
	checks += 3;
	assert (!mem_read && !mem_write) else begin
		$display("Data port is active while reset is held");
		test_errors++;
	end
	@(negedge clk);
	arst_n = 1'b1;
	cycles = 0;
	while (!ifetch_read && cycles < wait_limit) begin
		@(negedge clk);
		cycles++;
	end
	assert (ifetch_read && !mem_read && !mem_write) else begin
		$display("Fetch did not start or data port went active after reset");
		test_errors++;
	end
	assert (ifetch_address === reset_vector[15:4]) else begin
		$display("Mismatch in test reset: ifetch_address expected %h, actual %h",
			reset_vector[15:4], ifetch_address);
		test_errors++;
	end
	finish_test("reset");
endtask

task automatic test_add();
	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] word;
	logic [4:0] imm_a;
	logic [4:0] imm_b;
	bit finished;
	hold_reset();
	a = random_word();
	b = random_word();
	word = random_word();
	imm_a = {1'b1, word[3:0]};
	imm_b = {1'b1, word[7:4]};
	mem_words[data_word] = a;
	mem_words[data_word + 1] = b;
	emit_prologue();
	append_with_gap(mem_instr(lc3b_pkg::op_ldr, 3'd1, 3'd7, 6'd0));
	append_with_gap(mem_instr(lc3b_pkg::op_ldr, 3'd2, 3'd7, 6'd1));
	append_with_gap(alu_instr(lc3b_pkg::op_add, 3'd3, 3'd1, 1'b0, 5'd2));
	append_with_gap(alu_instr(lc3b_pkg::op_add, 3'd4, 3'd1, 1'b1, imm_a));
	append_with_gap(alu_instr(lc3b_pkg::op_add, 3'd5, 3'd2, 1'b1, imm_b));
	append_instr(mem_instr(lc3b_pkg::op_str, 3'd3, 3'd7, 6'd8));
	append_instr(mem_instr(lc3b_pkg::op_str, 3'd4, 3'd7, 6'd9));
	append_instr(mem_instr(lc3b_pkg::op_str, 3'd5, 3'd7, 6'd10));
	emit_epilogue();
	run_program("add", finished);
	if (finished) begin
		check_word("add", 8, expected_alu(lc3b_pkg::op_add, a, b, 1'b0, 5'd0));
		check_word("add", 9, expected_alu(lc3b_pkg::op_add, a, b, 1'b1, imm_a));
		check_word("add", 10, expected_alu(lc3b_pkg::op_add, b, a, 1'b1, imm_b));
	end
	finish_test("add");
endtask

task automatic test_logic();
	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] word;
	logic [4:0] imm;
	bit finished;
	hold_reset();
	a = random_word();
	b = random_word();
	word = random_word();
	imm = word[4:0];
	mem_words[data_word] = a;
	mem_words[data_word + 1] = b;
	emit_prologue();
	append_with_gap(mem_instr(lc3b_pkg::op_ldr, 3'd1, 3'd7, 6'd0));
	append_with_gap(mem_instr(lc3b_pkg::op_ldr, 3'd2, 3'd7, 6'd1));
	append_with_gap(alu_instr(lc3b_pkg::op_and, 3'd3, 3'd1, 1'b0, 5'd2));
	append_with_gap(alu_instr(lc3b_pkg::op_and, 3'd4, 3'd1, 1'b1, imm));
	append_with_gap(alu_instr(lc3b_pkg::op_not, 3'd5, 3'd2, 1'b1, 5'h1f));
	append_instr(mem_instr(lc3b_pkg::op_str, 3'd3, 3'd7, 6'd8));
	append_instr(mem_instr(lc3b_pkg::op_str, 3'd4, 3'd7, 6'd9));
	append_instr(mem_instr(lc3b_pkg::op_str, 3'd5, 3'd7, 6'd10));
	emit_epilogue();
	run_program("logic", finished);
	if (finished) begin
		check_word("logic", 8, expected_alu(lc3b_pkg::op_and, a, b, 1'b0, 5'd0));
		check_word("logic", 9, expected_alu(lc3b_pkg::op_and, a, b, 1'b1, imm));
		check_word("logic", 10, expected_alu(lc3b_pkg::op_not, b, a, 1'b0, 5'd0));
	end
	finish_test("logic");
endtask

task automatic test_branch();
	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] value;
	logic [2:0] nzp;
	bit zero_case;
	bit finished;
	hold_reset();
	a = random_word();
	while (a == 16'h0000) begin
		a = random_word();
	end
	b = random_word();
	while (16'(a + b) == 16'h0000) begin
		b = random_word();
	end
	mem_words[data_word] = a;
	mem_words[data_word + 1] = b;
	mem_words[data_word + 2] = ~a + 16'd1;
	emit_prologue();
	append_with_gap(mem_instr(lc3b_pkg::op_ldr, 3'd1, 3'd7, 6'd0));
	append_with_gap(mem_instr(lc3b_pkg::op_ldr, 3'd2, 3'd7, 6'd1));
	append_with_gap(mem_instr(lc3b_pkg::op_ldr, 3'd4, 3'd7, 6'd2));
	// Target skips three delay slots and one store
	for (int c = 0; c < 4; c++) begin
		nzp = (c < 2) ? 3'b010 : 3'b101;
		zero_case = (c % 2 == 0);
		append_instr(alu_instr(lc3b_pkg::op_add, 3'd3, 3'd1, 1'b0, zero_case ? 5'd4 : 5'd2));
		append_instr(branch_instr(nzp, 9'd4));
		append_instr(mem_instr(lc3b_pkg::op_str, 3'd1, 3'd7, 6'(8 + c)));
		append_instr(16'h0000);
		append_instr(16'h0000);
		append_instr(mem_instr(lc3b_pkg::op_str, 3'd6, 3'd7, 6'(12 + c)));
	end
	emit_epilogue();
	run_program("branch", finished);
	if (finished) begin
		for (int c = 0; c < 4; c++) begin
			nzp = (c < 2) ? 3'b010 : 3'b101;
			zero_case = (c % 2 == 0);
			value = expected_alu(lc3b_pkg::op_add, a, zero_case ? ~a + 16'd1 : b, 1'b0, 5'd0);
			check_word("branch", 8 + c, a);
			check_word("branch", 12 + c, expected_taken(nzp, value)
				? fill_value(data_word + 12 + c) : done_marker);
		end
	end
	finish_test("branch");
endtask

task automatic test_line();
	logic [15:0] values [8];
	logic [15:0] word;
	bit finished;
	hold_reset();
	// Low bits hold the slot number so all eight values differ
	for (int k = 0; k < 8; k++) begin
		word = random_word();
		values[k] = {word[15:3], 3'(k)};
		mem_words[data_word + k] = values[k];
	end
	emit_prologue();
	for (int k = 0; k < 8; k++) begin
		append_with_gap(mem_instr(lc3b_pkg::op_ldr, 3'd1, 3'd7, 6'(k)));
		append_instr(mem_instr(lc3b_pkg::op_str, 3'd1, 3'd7, 6'(8 + k)));
	end
	for (int k = 0; k < 8; k++) begin
		append_with_gap(mem_instr(lc3b_pkg::op_ldr, 3'd2, 3'd7, 6'(8 + k)));
		append_instr(mem_instr(lc3b_pkg::op_str, 3'd2, 3'd7, 6'(16 + k)));
	end
	emit_epilogue();
	run_program("line", finished);
	if (finished) begin
		for (int k = 0; k < 8; k++) begin
			check_word("line", 8 + k, values[k]);
			check_word("line", 16 + k, values[k]);
		end
		for (int k = 24; k < done_slot; k++) begin
			check_word("line", k, fill_value(data_word + k));
		end
	end
	finish_test("line");
endtask

initial begin
	arst_n = 1'b0;
	operand_state = lcg_seed;
	test_errors = 0;
	checks = 0;
	passed_tests = 0;
	failed_tests = 0;
	test_reset();
	test_add();
	test_logic();
	test_branch();
	test_line();
	$display("Summary: %0d tests passed, %0d tests failed, %0d checks", passed_tests,
		failed_tests, checks);
	if (failed_tests == 0) begin
		$display("ALL TESTS PASSED");
	end else begin
		$display("SOME TESTS FAILED");
	end
	$finish;
end

endmodule : lc3b_cpu_tb

`default_nettype wire
